// File: hdl/hssl_pkg.sv
package hssl_pkg;

  // --------------------
  // sizes
  // --------------------
  localparam int key_bits     = 32;
  localparam int num_channels = 2;
  localparam int num_rregs    = 8;
  localparam int num_mregs    = 4;
  localparam int sft_bits     = 5;
  localparam int adr_bits     = 8;

  // --------------------
  // register map, word addresses
  // --------------------
  localparam logic [adr_bits-1:0] reg_mp_key   = 'd0;
  localparam logic [adr_bits-1:0] reg_mp_fmsk  = 'd1;
  localparam logic [adr_bits-1:0] reg_mp_fsft  = 'd5;
  // read-only packet counters
  localparam logic [adr_bits-1:0] reg_cnt_evt  = 'd9;
  localparam logic [adr_bits-1:0] reg_cnt_cfg  = 'd10;
  // routing table, one word per entry
  localparam logic [adr_bits-1:0] reg_rt_key   = 'd16;
  localparam logic [adr_bits-1:0] reg_rt_mask  = 'd24;
  localparam logic [adr_bits-1:0] reg_rt_route = 'd32;

  // --------------------
  // packets
  // --------------------
  typedef enum logic {
    pkt_mc  = 1'b0,
    pkt_cfg = 1'b1
  } pkt_kind_e;

  // multicast event view
  typedef struct packed {
    logic [key_bits-1:0] key;
    logic [31:0]         payload;
  } mc_body_t;

  // configuration write view
  typedef struct packed {
    logic [23:0]         spare;
    logic [adr_bits-1:0] adr;
    logic [31:0]         dat;
  } cfg_body_t;

  // same 64 bits, decoded by kind
  typedef union packed {
    mc_body_t  mc;
    cfg_body_t cfg;
  } pkt_body_u;

  typedef struct packed {
    pkt_kind_e kind;
    pkt_body_u body;
  } pkt_t;

  // --------------------
  // wishbone classic
  // --------------------
  typedef struct packed {
    logic                cyc;
    logic                stb;
    logic                we;
    logic [adr_bits-1:0] adr;
    logic [31:0]         dat;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

  // --------------------
  // settings and internal writes
  // --------------------
  typedef struct packed {
    logic [key_bits-1:0]                 key;
    logic [num_mregs-1:0][key_bits-1:0]  fmsk;
    logic [num_mregs-1:0][sft_bits-1:0]  fsft;
  } map_cfg_t;

  typedef struct packed {
    logic [num_rregs-1:0][key_bits-1:0]     key;
    logic [num_rregs-1:0][key_bits-1:0]     mask;
    logic [num_rregs-1:0][num_channels-1:0] route;
  } route_cfg_t;

  typedef struct packed {
    logic                vld;
    logic [adr_bits-1:0] adr;
    logic [31:0]         dat;
  } reg_wr_t;

endpackage

// File: hdl/hssl_reg_bank.sv
`timescale 1ns/1ps

module hssl_reg_bank (
  input  logic                 pl_clk0_buf_int,
  input  logic                 rst,
  input  hssl_pkg::wb_req_t    wb_req,
  output hssl_pkg::wb_rsp_t    wb_rsp,
  input  hssl_pkg::reg_wr_t    prx_wr,
  input  logic                 cnt_evt_inc,
  input  logic                 cnt_cfg_inc,
  output hssl_pkg::map_cfg_t   map_cfg,
  output hssl_pkg::route_cfg_t route_cfg
);

  import hssl_pkg::*;

  logic       ack_q;
  logic [31:0] rd_q;
  logic [31:0] rd_d;
  logic       wb_acc;
  logic [31:0] cnt_evt_q;
  logic [31:0] cnt_cfg_q;
  map_cfg_t   map_q;
  map_cfg_t   map_d;
  route_cfg_t route_q;
  route_cfg_t route_d;
  // port 0 packet write, port 1 wishbone
  reg_wr_t    wr_port [2];

  // --------------------
  // bus handshake
  // --------------------
  // new access, not the ack cycle
  assign wb_acc = wb_req.cyc && wb_req.stb && !ack_q;

  assign wr_port[0] = prx_wr;
  assign wr_port[1] = '{vld: wb_acc && wb_req.we, adr: wb_req.adr, dat: wb_req.dat};

  // --------------------
  // write decode
  // --------------------
  always_comb begin
    map_d   = map_q;
    route_d = route_q;
    // wishbone last, wins on same address
    for (int p = 0; p < 2; p++) begin
      if (wr_port[p].vld) begin
        if (wr_port[p].adr == reg_mp_key) begin
          map_d.key = wr_port[p].dat;
        end
        for (int i = 0; i < num_mregs; i++) begin
          if (wr_port[p].adr == reg_mp_fmsk + adr_bits'(i)) begin
            map_d.fmsk[i] = wr_port[p].dat;
          end
          if (wr_port[p].adr == reg_mp_fsft + adr_bits'(i)) begin
            map_d.fsft[i] = wr_port[p].dat[sft_bits-1:0];
          end
        end
        for (int i = 0; i < num_rregs; i++) begin
          if (wr_port[p].adr == reg_rt_key + adr_bits'(i)) begin
            route_d.key[i] = wr_port[p].dat;
          end
          if (wr_port[p].adr == reg_rt_mask + adr_bits'(i)) begin
            route_d.mask[i] = wr_port[p].dat;
          end
          if (wr_port[p].adr == reg_rt_route + adr_bits'(i)) begin
            route_d.route[i] = wr_port[p].dat[num_channels-1:0];
          end
        end
      end
    end
  end

  // --------------------
  // read decode
  // --------------------
  always_comb begin
    // unmapped reads give zero
    rd_d = '0;
    if (wb_req.adr == reg_mp_key) rd_d = map_q.key;
    if (wb_req.adr == reg_cnt_evt) rd_d = cnt_evt_q;
    if (wb_req.adr == reg_cnt_cfg) rd_d = cnt_cfg_q;
    for (int i = 0; i < num_mregs; i++) begin
      if (wb_req.adr == reg_mp_fmsk + adr_bits'(i)) rd_d = map_q.fmsk[i];
      if (wb_req.adr == reg_mp_fsft + adr_bits'(i)) rd_d = 32'(map_q.fsft[i]);
    end
    for (int i = 0; i < num_rregs; i++) begin
      if (wb_req.adr == reg_rt_key + adr_bits'(i)) rd_d = route_q.key[i];
      if (wb_req.adr == reg_rt_mask + adr_bits'(i)) rd_d = route_q.mask[i];
      if (wb_req.adr == reg_rt_route + adr_bits'(i)) rd_d = 32'(route_q.route[i]);
    end
  end

  always_ff @(posedge pl_clk0_buf_int) begin
    if (rst) begin
      ack_q     <= 1'b0;
      map_q     <= '0;
      route_q   <= '0;
      cnt_evt_q <= '0;
      cnt_cfg_q <= '0;
    end else begin
      // single-cycle ack
      ack_q     <= wb_acc;
      map_q     <= map_d;
      route_q   <= route_d;
      // wrapping counters
      cnt_evt_q <= cnt_evt_q + 32'(cnt_evt_inc);
      cnt_cfg_q <= cnt_cfg_q + 32'(cnt_cfg_inc);
    end
  end

  // read data captured with ack
  always_ff @(posedge pl_clk0_buf_int) begin
    if (wb_acc) rd_q <= rd_d;
  end

  assign wb_rsp    = '{ack: ack_q, dat: rd_q};
  assign map_cfg   = map_q;
  assign route_cfg = route_q;

endmodule

// File: hdl/pkt_assembler.sv
`timescale 1ns/1ps

module pkt_assembler (
  input  logic                          pl_clk0_buf_int,
  input  logic                          rst,
  input  hssl_pkg::map_cfg_t            map_cfg,
  input  logic [hssl_pkg::key_bits-1:0] evt_data,
  input  logic                          evt_vld,
  output logic                          evt_rdy,
  output hssl_pkg::pkt_t                pkt,
  output logic                          pkt_vld,
  input  logic                          pkt_rdy
);

  import hssl_pkg::*;

  logic [key_bits-1:0] key_d;
  pkt_t                pkt_d;

  // --------------------
  // key mapping
  // --------------------
  always_comb begin
    key_d = map_cfg.key;
    // mask, shift down, merge into base key
    for (int i = 0; i < num_mregs; i++) begin
      key_d = key_d | ((evt_data & map_cfg.fmsk[i]) >> map_cfg.fsft[i]);
    end
    pkt_d                 = '0;
    pkt_d.kind            = pkt_mc;
    pkt_d.body.mc.key     = key_d;
    // raw event rides as payload
    pkt_d.body.mc.payload = evt_data;
  end

  // --------------------
  // one-entry output register
  // --------------------
  // free or draining this cycle
  assign evt_rdy = !pkt_vld || pkt_rdy;

  always_ff @(posedge pl_clk0_buf_int) begin
    if (rst) begin
      pkt_vld <= 1'b0;
    end else if (evt_rdy) begin
      pkt_vld <= evt_vld;
    end
  end

  always_ff @(posedge pl_clk0_buf_int) begin
    if (evt_vld && evt_rdy) pkt <= pkt_d;
  end

endmodule

// File: hdl/pkt_router.sv
`timescale 1ns/1ps

module pkt_router (
  input  logic                              pl_clk0_buf_int,
  input  logic                              rst,
  input  hssl_pkg::route_cfg_t              route_cfg,
  input  hssl_pkg::pkt_t                    pkt,
  input  logic                              pkt_vld,
  output logic                              pkt_rdy,
  output hssl_pkg::pkt_t                    tx_pkt,
  output logic [hssl_pkg::num_channels-1:0] tx_vld,
  input  logic [hssl_pkg::num_channels-1:0] tx_rdy
);

  import hssl_pkg::*;

  logic [num_rregs-1:0]    hit;
  logic [num_channels-1:0] route_d;
  logic [num_channels-1:0] pend_q;
  logic [num_channels-1:0] pend_left;

  // --------------------
  // table lookup
  // --------------------
  always_comb begin
    for (int i = 0; i < num_rregs; i++) begin
      hit[i] = (pkt.body.mc.key & route_cfg.mask[i]) == route_cfg.key[i];
    end
    // no hit drops the packet
    route_d = '0;
    // walk down so the lowest hit wins
    for (int i = num_rregs - 1; i >= 0; i--) begin
      if (hit[i]) route_d = route_cfg.route[i];
    end
  end

  // --------------------
  // pending channels
  // --------------------
  // channels still owed after this edge
  assign pend_left = pend_q & ~tx_rdy;
  assign pkt_rdy   = (pend_left == '0);
  assign tx_vld    = pend_q;

  always_ff @(posedge pl_clk0_buf_int) begin
    if (rst) begin
      pend_q <= '0;
    end else if (pkt_vld && pkt_rdy) begin
      pend_q <= route_d;
    end else begin
      // each channel clears on its own handshake
      pend_q <= pend_left;
    end
  end

  // shared data for all channels
  always_ff @(posedge pl_clk0_buf_int) begin
    if (pkt_vld && pkt_rdy) tx_pkt <= pkt;
  end

endmodule

// File: hdl/pkt_receiver.sv
`timescale 1ns/1ps

module pkt_receiver (
  input  logic              pl_clk0_buf_int,
  input  logic              rst,
  input  hssl_pkg::pkt_t    rx_pkt,
  input  logic              rx_vld,
  output logic              rx_rdy,
  output hssl_pkg::reg_wr_t prx_wr,
  output logic              cnt_evt_inc,
  output logic              cnt_cfg_inc
);

  import hssl_pkg::*;

  logic                rx_acc;
  logic                is_cfg;
  logic                wr_vld_q;
  logic [adr_bits-1:0] wr_adr_q;
  logic [31:0]         wr_dat_q;

  // never back-pressures
  assign rx_rdy = 1'b1;
  assign rx_acc = rx_vld && rx_rdy;
  assign is_cfg = (rx_pkt.kind == pkt_cfg);

  // --------------------
  // decode and count
  // --------------------
  always_ff @(posedge pl_clk0_buf_int) begin
    if (rst) begin
      wr_vld_q    <= 1'b0;
      cnt_evt_inc <= 1'b0;
      cnt_cfg_inc <= 1'b0;
    end else begin
      wr_vld_q    <= rx_acc && is_cfg;
      // one pulse per packet, by kind
      cnt_evt_inc <= rx_acc && !is_cfg;
      cnt_cfg_inc <= rx_acc && is_cfg;
    end
  end

  // config view of the body
  always_ff @(posedge pl_clk0_buf_int) begin
    if (rx_acc) begin
      wr_adr_q <= rx_pkt.body.cfg.adr;
      wr_dat_q <= rx_pkt.body.cfg.dat;
    end
  end

  assign prx_wr = '{vld: wr_vld_q, adr: wr_adr_q, dat: wr_dat_q};

endmodule

// File: hdl/dvs_on_hssl_top.sv
`timescale 1ns/1ps

module dvs_on_hssl_top (
  input  logic                                pl_clk0_buf_int,
  input  logic                                rst,

  // wishbone register access
  input  hssl_pkg::wb_req_t                   wb_req,
  output hssl_pkg::wb_rsp_t                   wb_rsp,

  // events in
  input  logic [hssl_pkg::key_bits-1:0]       evt_data,
  input  logic                                evt_vld,
  output logic                                evt_rdy,

  // routed packets out, shared data
  output hssl_pkg::pkt_t                      tx_pkt,
  output logic [hssl_pkg::num_channels-1:0]   tx_vld,
  input  logic [hssl_pkg::num_channels-1:0]   tx_rdy,

  // received packets in
  input  hssl_pkg::pkt_t                      rx_pkt,
  input  logic                                rx_vld,
  output logic                                rx_rdy
);

  import hssl_pkg::*;

  // --------------------
  // internal wiring
  // --------------------
  map_cfg_t   map_cfg;
  route_cfg_t route_cfg;
  reg_wr_t    prx_wr;
  logic       cnt_evt_inc;
  logic       cnt_cfg_inc;

  // assembler to router
  pkt_t       pkt;
  logic       pkt_vld;
  logic       pkt_rdy;

  // settings, counters, bus slave
  hssl_reg_bank rb (
    .pl_clk0_buf_int (pl_clk0_buf_int),
    .rst             (rst),
    .wb_req          (wb_req),
    .wb_rsp          (wb_rsp),
    .prx_wr          (prx_wr),
    .cnt_evt_inc     (cnt_evt_inc),
    .cnt_cfg_inc     (cnt_cfg_inc),
    .map_cfg         (map_cfg),
    .route_cfg       (route_cfg)
  );

  // events to multicast packets
  pkt_assembler pa (
    .pl_clk0_buf_int (pl_clk0_buf_int),
    .rst             (rst),
    .map_cfg         (map_cfg),
    .evt_data        (evt_data),
    .evt_vld         (evt_vld),
    .evt_rdy         (evt_rdy),
    .pkt             (pkt),
    .pkt_vld         (pkt_vld),
    .pkt_rdy         (pkt_rdy)
  );

  // table lookup, multicast to channels
  pkt_router pr (
    .pl_clk0_buf_int (pl_clk0_buf_int),
    .rst             (rst),
    .route_cfg       (route_cfg),
    .pkt             (pkt),
    .pkt_vld         (pkt_vld),
    .pkt_rdy         (pkt_rdy),
    .tx_pkt          (tx_pkt),
    .tx_vld          (tx_vld),
    .tx_rdy          (tx_rdy)
  );

  // incoming packets, config writes and counts
  pkt_receiver prx (
    .pl_clk0_buf_int (pl_clk0_buf_int),
    .rst             (rst),
    .rx_pkt          (rx_pkt),
    .rx_vld          (rx_vld),
    .rx_rdy          (rx_rdy),
    .prx_wr          (prx_wr),
    .cnt_evt_inc     (cnt_evt_inc),
    .cnt_cfg_inc     (cnt_cfg_inc)
  );

endmodule

// File: verif/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
  output logic pl_clk0_buf_int,
  output logic rst
);

  localparam int half_period_ns = 10;
  localparam int rst_cycles     = 10;

  // free-running 20 ns clock
  initial begin
    pl_clk0_buf_int = 1'b0;
    forever #half_period_ns pl_clk0_buf_int = ~pl_clk0_buf_int;
  end

  // reset held for the first cycles, released just after an edge
  initial begin
    rst = 1'b1;
    repeat (rst_cycles) @(posedge pl_clk0_buf_int);
    #1;
    rst = 1'b0;
  end

endmodule

// File: verif/dvs_on_hssl_sva.sv
`timescale 1ns/1ps

module dvs_on_hssl_sva (
  input logic                              pl_clk0_buf_int,
  input logic                              rst,
  input hssl_pkg::wb_rsp_t                 wb_rsp,
  input hssl_pkg::pkt_t                    pkt,
  input logic                              pkt_vld,
  input logic                              pkt_rdy,
  input hssl_pkg::pkt_t                    tx_pkt,
  input logic [hssl_pkg::num_channels-1:0] tx_vld,
  input logic [hssl_pkg::num_channels-1:0] tx_rdy
);

  // one counter per assertion, summed for the testbench
  int fail_ack  = 0;
  int fail_tx   = 0;
  int fail_pkt  = 0;
  int fail_rst  = 0;
  int fails;

  // channels stalled this cycle
  logic [hssl_pkg::num_channels-1:0] stalled;

  assign stalled = tx_vld & ~tx_rdy;
  assign fails   = fail_ack + fail_tx + fail_pkt + fail_rst;

  // --------------------
  // wishbone
  // --------------------
  ack_pulse: assert property (@(posedge pl_clk0_buf_int) disable iff (rst)
    wb_rsp.ack |=> !wb_rsp.ack)
  else begin
    $error("wishbone ack stayed high for more than one cycle");
    fail_ack++;
  end

  // --------------------
  // streams under back-pressure
  // --------------------
  // stalled channels keep valid, shared data holds
  tx_hold: assert property (@(posedge pl_clk0_buf_int) disable iff (rst)
    stalled != '0 |=> ((tx_vld & $past(stalled)) == $past(stalled)) && $stable(tx_pkt))
  else begin
    $error("channel output dropped or changed while stalled");
    fail_tx++;
  end

  // assembler to router link
  pkt_hold: assert property (@(posedge pl_clk0_buf_int) disable iff (rst)
    pkt_vld && !pkt_rdy |=> pkt_vld && $stable(pkt))
  else begin
    $error("assembled packet changed while the router was busy");
    fail_pkt++;
  end

  // --------------------
  // reset values
  // --------------------
  rst_quiet: assert property (@(posedge pl_clk0_buf_int)
    rst |=> !wb_rsp.ack && tx_vld == '0 && !pkt_vld)
  else begin
    $error("ack or a valid was high right after reset");
    fail_rst++;
  end

endmodule

bind dvs_on_hssl_top dvs_on_hssl_sva sva_chk (
  .pl_clk0_buf_int (pl_clk0_buf_int),
  .rst             (rst),
  .wb_rsp          (wb_rsp),
  .pkt             (pkt),
  .pkt_vld         (pkt_vld),
  .pkt_rdy         (pkt_rdy),
  .tx_pkt          (tx_pkt),
  .tx_vld          (tx_vld),
  .tx_rdy          (tx_rdy)
);

// File: verif/dvs_on_hssl_tb.sv
`timescale 1ns/1ps

module dvs_on_hssl_tb;

  import hssl_pkg::*;

  // about 600 cycles for all tests, limit at five times that
  localparam int est_cycles     = 600;
  localparam int timeout_cycles = 5 * est_cycles;
  localparam int num_events     = 20;

  logic                    pl_clk0_buf_int;
  logic                    rst;
  wb_req_t                 wb_req;
  wb_rsp_t                 wb_rsp;
  logic [key_bits-1:0]     evt_data;
  logic                    evt_vld;
  logic                    evt_rdy;
  pkt_t                    tx_pkt;
  logic [num_channels-1:0] tx_vld;
  logic [num_channels-1:0] tx_rdy;
  pkt_t                    rx_pkt;
  logic                    rx_vld;
  logic                    rx_rdy;

  // expected register contents, zero after reset
  logic [31:0]             sh_key = '0;
  logic [31:0]             sh_fmsk  [num_mregs] = '{default: '0};
  logic [sft_bits-1:0]     sh_fsft  [num_mregs] = '{default: '0};
  logic [31:0]             sh_rkey  [num_rregs] = '{default: '0};
  logic [31:0]             sh_rmask [num_rregs] = '{default: '0};
  logic [num_channels-1:0] sh_route [num_rregs] = '{default: '0};

  // packets owed to each channel, in order
  mc_body_t exp_q [num_channels][$];

  int   errors     = 0;
  int   checks     = 0;
  int   mon_errors = 0;
  int   mon_checks = 0;
  int   tests      = 0;
  int   err_mark   = 0;
  int   cycles     = 0;
  int   n_mc       = 0;
  int   n_cfg      = 0;
  int   stall_left;
  logic stall_on;

  tb_clk_gen clk_gen (
    .pl_clk0_buf_int (pl_clk0_buf_int),
    .rst             (rst)
  );

  dvs_on_hssl_top dvs_on_hssl_top_i (.*);

  // --------------------
  // reference model
  // --------------------
  function automatic bit in_block(input int a, input logic [adr_bits-1:0] base, input int n);
    return a >= int'(base) && a < int'(base) + n;
  endfunction

  // implemented bits per register, zero when unmapped or read-only
  function automatic logic [31:0] reg_mask(input int a);
    if (a == int'(reg_mp_key)) return '1;
    if (in_block(a, reg_mp_fmsk, num_mregs)) return '1;
    if (in_block(a, reg_mp_fsft, num_mregs)) return 32'((1 << sft_bits) - 1);
    if (in_block(a, reg_rt_key, num_rregs)) return '1;
    if (in_block(a, reg_rt_mask, num_rregs)) return '1;
    if (in_block(a, reg_rt_route, num_rregs)) return 32'((1 << num_channels) - 1);
    return '0;
  endfunction

  function automatic void shadow_write(input int a, input logic [31:0] d);
    if (a == int'(reg_mp_key)) sh_key = d;
    if (in_block(a, reg_mp_fmsk, num_mregs)) sh_fmsk[a - int'(reg_mp_fmsk)] = d;
    if (in_block(a, reg_mp_fsft, num_mregs)) sh_fsft[a - int'(reg_mp_fsft)] = d[sft_bits-1:0];
    if (in_block(a, reg_rt_key, num_rregs)) sh_rkey[a - int'(reg_rt_key)] = d;
    if (in_block(a, reg_rt_mask, num_rregs)) sh_rmask[a - int'(reg_rt_mask)] = d;
    if (in_block(a, reg_rt_route, num_rregs)) begin
      sh_route[a - int'(reg_rt_route)] = d[num_channels-1:0];
    end
  endfunction

  // base key ORed with every masked, right-shifted field
  function automatic logic [31:0] expect_key(input logic [31:0] evt);
    logic [31:0] k;
    k = sh_key;
    for (int i = 0; i < num_mregs; i++) begin
      k = k | ((evt & sh_fmsk[i]) >> sh_fsft[i]);
    end
    return k;
  endfunction

  // first hit from entry 0 upward, none means drop
  function automatic logic [num_channels-1:0] expect_route(input logic [31:0] key);
    for (int i = 0; i < num_rregs; i++) begin
      if ((key & sh_rmask[i]) == sh_rkey[i]) return sh_route[i];
    end
    return '0;
  endfunction

  function automatic int total_errors();
    return errors + mon_errors + dvs_on_hssl_top_i.sva_chk.fails;
  endfunction

  function automatic pkt_t cfg_packet(input logic [adr_bits-1:0] adr, input logic [31:0] dat);
    pkt_t p;
    p               = '0;
    p.kind          = pkt_cfg;
    p.body.cfg.adr  = adr;
    p.body.cfg.dat  = dat;
    return p;
  endfunction

  function automatic pkt_t mc_packet(input logic [31:0] key, input logic [31:0] payload);
    pkt_t p;
    p.kind    = pkt_mc;
    p.body.mc = '{key: key, payload: payload};
    return p;
  endfunction

  task automatic check_equal(input logic [31:0] got, input logic [31:0] want, input string what);
    checks++;
    assert (got === want) else begin
      $display("FAIL %0t: %s read %h, expected %h", $time, what, got, want);
      errors++;
    end
  endtask

  // --------------------
  // bus and stream drivers
  // --------------------
  task automatic bus_cycle(input logic we, input logic [adr_bits-1:0] adr,
                           input logic [31:0] dat, output logic [31:0] rdat);
    @(posedge pl_clk0_buf_int);
    #1;
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
    do begin
      @(negedge pl_clk0_buf_int);
    end while (!wb_rsp.ack);
    rdat = wb_rsp.dat;
    // strobe drops after the ack edge
    @(posedge pl_clk0_buf_int);
    #1;
    wb_req = '0;
  endtask

  task automatic wb_write(input logic [adr_bits-1:0] adr, input logic [31:0] dat);
    logic [31:0] unused;
    bus_cycle(1'b1, adr, dat, unused);
    shadow_write(int'(adr), dat);
  endtask

  task automatic wb_read(input logic [adr_bits-1:0] adr, output logic [31:0] rdat);
    bus_cycle(1'b0, adr, '0, rdat);
  endtask

  task automatic send_event(input logic [31:0] evt);
    mc_body_t                want;
    logic [num_channels-1:0] route;
    want  = '{key: expect_key(evt), payload: evt};
    route = expect_route(want.key);
    @(posedge pl_clk0_buf_int);
    #1;
    evt_data = evt;
    evt_vld  = 1'b1;
    do begin
      @(negedge pl_clk0_buf_int);
    end while (!evt_rdy);
    for (int c = 0; c < num_channels; c++) begin
      if (route[c]) exp_q[c].push_back(want);
    end
    @(posedge pl_clk0_buf_int);
    #1;
    evt_vld = 1'b0;
  endtask

  task automatic send_rx(input pkt_t p);
    @(posedge pl_clk0_buf_int);
    #1;
    rx_pkt = p;
    rx_vld = 1'b1;
    do begin
      @(negedge pl_clk0_buf_int);
    end while (!rx_rdy);
    if (p.kind == pkt_cfg) begin
      shadow_write(int'(p.body.cfg.adr), p.body.cfg.dat);
      n_cfg++;
    end else begin
      n_mc++;
    end
    @(posedge pl_clk0_buf_int);
    #1;
    rx_vld = 1'b0;
  endtask

  // wait until every owed packet is out, then expect silence
  task automatic drain();
    int owed;
    do begin
      @(negedge pl_clk0_buf_int);
      owed = 0;
      for (int c = 0; c < num_channels; c++) owed += exp_q[c].size();
    end while (owed != 0);
    repeat (4) begin
      @(negedge pl_clk0_buf_int);
      checks++;
      assert (tx_vld == '0) else begin
        $display("FAIL %0t: channel valid %b with no packet expected", $time, tx_vld);
        errors++;
      end
    end
  endtask

  task automatic start_test();
    tests++;
    err_mark = total_errors();
  endtask

  task automatic end_test(input string name);
    int n;
    n = total_errors() - err_mark;
    if (n == 0) $display("test %0d %s: ok", tests, name);
    else $display("test %0d %s: %0d errors", tests, name, n);
  endtask

  // --------------------
  // channel monitor
  // --------------------
  function automatic void check_delivery(input int c);
    mc_body_t want;
    mon_checks++;
    assert (exp_q[c].size() != 0) else begin
      $display("channel %0d sent a packet that no event asked for, at %0t", c, $time);
      mon_errors++;
    end
    if (exp_q[c].size() != 0) begin
      want = exp_q[c].pop_front();
      assert (tx_pkt.kind == pkt_mc && tx_pkt.body.mc == want) else begin
        $display("FAIL %0t: channel %0d got key %h payload %h, expected %h %h", $time, c,
                 tx_pkt.body.mc.key, tx_pkt.body.mc.payload, want.key, want.payload);
        mon_errors++;
      end
    end
  endfunction

  // handshake seen mid-cycle, transfer on the next edge
  always @(negedge pl_clk0_buf_int) begin
    for (int c = 0; c < num_channels; c++) begin
      if (!rst && tx_vld[c] && tx_rdy[c]) check_delivery(c);
    end
  end

  // channel 1 ready toggles in random stretches while stalling is on
  initial begin
    tx_rdy     = '1;
    stall_left = 0;
    forever begin
      @(posedge pl_clk0_buf_int);
      #1;
      if (stall_left == 0) begin
        stall_left = $urandom_range(1, 6);
        tx_rdy[1]  = stall_on ? !tx_rdy[1] : 1'b1;
      end else begin
        stall_left--;
      end
    end
  end

  always @(posedge pl_clk0_buf_int) begin
    cycles++;
    if (cycles >= timeout_cycles) begin
      $display("run stopped, no finish after %0d cycles", cycles);
      $display("TB FAILED");
      $finish;
    end
  end

  // --------------------
  // tests
  // --------------------
  initial begin
    logic [31:0]         rdat;
    logic [31:0]         wr_val [64];
    logic [adr_bits-1:0] zero_adr [5];
    void'($urandom(81717));
    zero_adr = '{reg_cnt_evt, reg_cnt_cfg, 8'd12, 8'd40, 8'd255};
    wb_req   = '0;
    evt_data = '0;
    evt_vld  = 1'b0;
    rx_pkt   = '0;
    rx_vld   = 1'b0;
    stall_on = 1'b0;
    wait (rst == 1'b0);

    // every writable register, then read back
    start_test();
    for (int a = 0; a < 64; a++) begin
      wr_val[a] = $urandom() & reg_mask(a);
      if (reg_mask(a) != '0) wb_write(adr_bits'(a), wr_val[a]);
    end
    for (int a = 0; a < 64; a++) begin
      if (reg_mask(a) != '0) begin
        wb_read(adr_bits'(a), rdat);
        check_equal(rdat, wr_val[a], $sformatf("register %0d", a));
      end
    end
    // counters and holes
    foreach (zero_adr[i]) begin
      wb_read(zero_adr[i], rdat);
      check_equal(rdat, '0, $sformatf("register %0d", zero_adr[i]));
    end
    end_test("wishbone registers");

    // random mapper, entry 0 matches all on both channels
    start_test();
    wb_write(reg_mp_key, $urandom() & 32'hff00_0000);
    for (int i = 0; i < num_mregs; i++) begin
      wb_write(reg_mp_fmsk + adr_bits'(i), $urandom());
      wb_write(reg_mp_fsft + adr_bits'(i), $urandom_range(0, 31));
    end
    wb_write(reg_rt_key, '0);
    wb_write(reg_rt_mask, '0);
    wb_write(reg_rt_route, 32'h3);
    repeat (num_events) send_event($urandom());
    drain();
    end_test("event assembly");

    start_test();
    stall_on = 1'b1;
    repeat (num_events) send_event($urandom());
    drain();
    stall_on = 1'b0;
    end_test("multicast under back-pressure");

    // key equals event from here on
    start_test();
    wb_write(reg_mp_key, '0);
    for (int i = 0; i < num_mregs; i++) begin
      wb_write(reg_mp_fmsk + adr_bits'(i), (i == 0) ? '1 : '0);
      wb_write(reg_mp_fsft + adr_bits'(i), '0);
    end
    // entry 0 inside entry 1, different routes
    wb_write(reg_rt_key, 32'h100);
    wb_write(reg_rt_mask, 32'hf00);
    wb_write(reg_rt_route, 32'h1);
    wb_write(reg_rt_key + 8'd1, 32'h100);
    wb_write(reg_rt_mask + 8'd1, 32'h100);
    wb_write(reg_rt_route + 8'd1, 32'h2);
    // the rest only match all-ones
    for (int i = 2; i < num_rregs; i++) begin
      wb_write(reg_rt_key + adr_bits'(i), '1);
      wb_write(reg_rt_mask + adr_bits'(i), '1);
      wb_write(reg_rt_route + adr_bits'(i), 32'h3);
    end
    send_event(32'h0000_0123);
    send_event(32'h0000_0345);
    send_event(32'h0000_0045);
    drain();
    end_test("priority and drop");

    // table rewritten through configuration packets
    start_test();
    send_rx(cfg_packet(reg_rt_key, 32'h200));
    send_rx(cfg_packet(reg_rt_mask, 32'hf00));
    send_rx(cfg_packet(reg_rt_route, 32'h2));
    send_rx(cfg_packet(reg_rt_key + 8'd1, '0));
    send_rx(cfg_packet(reg_rt_mask + 8'd1, '0));
    send_rx(cfg_packet(reg_rt_route + 8'd1, 32'h1));
    repeat (3) send_rx(mc_packet($urandom(), $urandom()));
    send_event(32'h0000_02ab);
    send_event(32'h0000_07cd);
    send_event(32'h0000_02ff);
    drain();
    wb_read(reg_cnt_evt, rdat);
    check_equal(rdat, 32'(n_mc), "multicast packet count");
    wb_read(reg_cnt_cfg, rdat);
    check_equal(rdat, 32'(n_cfg), "configuration packet count");
    end_test("received packets");

    $display("tests %0d, checks %0d, errors %0d", tests, checks + mon_checks, total_errors());
    if (total_errors() == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: dvs_on_hssl_top.f
hdl/hssl_pkg.sv
hdl/hssl_reg_bank.sv
hdl/pkt_assembler.sv
hdl/pkt_router.sv
hdl/pkt_receiver.sv
hdl/dvs_on_hssl_top.sv
verif/tb_clk_gen.sv
verif/dvs_on_hssl_sva.sv
verif/dvs_on_hssl_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= dvs_on_hssl_tb
FILELIST  ?= dvs_on_hssl_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?=

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# pass only when the simulation prints its pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)
